/* mc_pkg.sv */
/*
 * DRAM command path, shared definitions
 * address widths and typedefs for bank, row and column,
 * plus the command encoding seen on the command output
 */

package mc_pkg;

    ////////////////////////////////////////////////////////////////////////////
    // address widths
    ////////////////////////////////////////////////////////////////////////////

    localparam int BANK_WIDTH = 3;  // bank group + bank
    localparam int ROW_WIDTH  = 16;
    localparam int COL_WIDTH  = 10;

    // every bank address is tracked in the page table
    localparam int NUM_BANKS = 1 << BANK_WIDTH;

    ////////////////////////////////////////////////////////////////////////////
    // address types
    ////////////////////////////////////////////////////////////////////////////

    typedef logic [BANK_WIDTH-1:0] bank_t;
    typedef logic [ROW_WIDTH-1:0]  row_t;
    typedef logic [COL_WIDTH-1:0]  col_t;

    ////////////////////////////////////////////////////////////////////////////
    // dram commands
    ////////////////////////////////////////////////////////////////////////////

    typedef enum logic [2:0] {
        CMD_NOP = 3'd0,  // idle slot
        CMD_PRE = 3'd1,  // close the open row of a bank
        CMD_ACT = 3'd2,  // open a row
        CMD_RD  = 3'd3,  // column read
        CMD_WR  = 3'd4   // column write
    } dram_cmd_e;

endpackage

/* mc_request_queue.sv */
/*
 * Request queue
 * four-phase req/ack intake in front of an in-order FIFO;
 * one entry is written per handshake, the oldest entry is
 * presented to the scheduler and dropped on a pop
 */

`timescale 1ns/1ps

module mc_request_queue #(
    parameter int QUEUE_DEPTH = 4
) (
    input  logic          clk,
    input  logic          i_reset,
    // requester side
    input  logic          i_req,
    input  logic          i_req_write,
    input  mc_pkg::bank_t i_req_bank,
    input  mc_pkg::row_t  i_req_row,
    input  mc_pkg::col_t  i_req_col,
    output logic          o_ack,
    // scheduler side
    input  logic          i_pop,
    output logic          o_valid,
    output logic          o_write,
    output mc_pkg::bank_t o_bank,
    output mc_pkg::row_t  o_row,
    output mc_pkg::col_t  o_col
);

    localparam int PTR_W = (QUEUE_DEPTH > 1) ? $clog2(QUEUE_DEPTH) : 1;
    localparam int CNT_W = $clog2(QUEUE_DEPTH + 1);

    logic             req_q;  // sampled i_req
    logic             ack_q;
    logic             push;
    logic             full;
    logic [PTR_W-1:0] wr_ptr;
    logic [PTR_W-1:0] rd_ptr;
    logic [CNT_W-1:0] count;

    // entry storage
    logic          mem_write [QUEUE_DEPTH];
    mc_pkg::bank_t mem_bank  [QUEUE_DEPTH];
    mc_pkg::row_t  mem_row   [QUEUE_DEPTH];
    mc_pkg::col_t  mem_col   [QUEUE_DEPTH];

    ////////////////////////////////////////////////////////////////////////////
    // handshake
    ////////////////////////////////////////////////////////////////////////////

    assign full = (count == CNT_W'(QUEUE_DEPTH));
    assign push = req_q && !ack_q && !full;  // held off while full

    always_ff @(posedge clk) begin
        if (i_reset) begin
            req_q <= 1'b0;
            ack_q <= 1'b0;
        end else begin
            req_q <= i_req;
            if (push)
                ack_q <= 1'b1;
            else if (!req_q)
                ack_q <= 1'b0;  // requester has dropped i_req
        end
    end

    assign o_ack = ack_q;

    ////////////////////////////////////////////////////////////////////////////
    // fifo
    ////////////////////////////////////////////////////////////////////////////

    always_ff @(posedge clk) begin
        if (i_reset) begin
            wr_ptr <= '0;
            rd_ptr <= '0;
            count  <= '0;
        end else begin
            if (push)
                wr_ptr <= (wr_ptr == PTR_W'(QUEUE_DEPTH - 1)) ? '0 : wr_ptr + 1'b1;
            if (i_pop)
                rd_ptr <= (rd_ptr == PTR_W'(QUEUE_DEPTH - 1)) ? '0 : rd_ptr + 1'b1;
            case ({push, i_pop})
                2'b10:   count <= count + 1'b1;
                2'b01:   count <= count - 1'b1;
                default: count <= count;
            endcase
        end
    end

    // fields are stable while i_req is high
    always_ff @(posedge clk) begin
        if (push) begin
            mem_write[wr_ptr] <= i_req_write;
            mem_bank[wr_ptr]  <= i_req_bank;
            mem_row[wr_ptr]   <= i_req_row;
            mem_col[wr_ptr]   <= i_req_col;
        end
    end

    assign o_valid = (count != '0);
    assign o_write = mem_write[rd_ptr];
    assign o_bank  = mem_bank[rd_ptr];
    assign o_row   = mem_row[rd_ptr];
    assign o_col   = mem_col[rd_ptr];

    // scheduler only pops an entry it has been shown
    a_pop_not_empty: assert property (@(posedge clk) disable iff (i_reset)
        i_pop |-> o_valid)
        else $error("queue popped while empty");

    // fill level never passes the depth
    a_no_write_full: assert property (@(posedge clk) disable iff (i_reset)
        count <= CNT_W'(QUEUE_DEPTH))
        else $error("queue written while full");

endmodule

/* mc_page_table.sv */
/*
 * Page table
 * open flag and open row for every bank; lookups answer
 * in the same cycle, updates take effect at the next edge
 */

`timescale 1ns/1ps

module mc_page_table (
    input  logic          clk,
    input  logic          i_reset,
    // lookup
    input  mc_pkg::bank_t i_lookup_bank,
    output logic          o_open,
    output mc_pkg::row_t  o_open_row,
    // update after PRE or ACT
    input  logic          i_upd_valid,
    input  logic          i_upd_open,
    input  mc_pkg::bank_t i_upd_bank,
    input  mc_pkg::row_t  i_upd_row
);

    logic [mc_pkg::NUM_BANKS-1:0] open_q;
    mc_pkg::row_t                 row_q [mc_pkg::NUM_BANKS];

    // all banks start precharged
    always_ff @(posedge clk) begin
        if (i_reset)
            open_q <= '0;
        else if (i_upd_valid)
            open_q[i_upd_bank] <= i_upd_open;
    end

    // row is only meaningful while the flag is set
    always_ff @(posedge clk) begin
        if (i_upd_valid && i_upd_open)
            row_q[i_upd_bank] <= i_upd_row;
    end

    assign o_open     = open_q[i_lookup_bank];
    assign o_open_row = row_q[i_lookup_bank];

    ////////////////////////////////////////////////////////////////////////////
    // checks on the scheduler's updates
    ////////////////////////////////////////////////////////////////////////////

    a_act_closed_bank: assert property (@(posedge clk) disable iff (i_reset)
        (i_upd_valid && i_upd_open) |-> !open_q[i_upd_bank])
        else $error("ACT to a bank that is already open");

    a_pre_open_bank: assert property (@(posedge clk) disable iff (i_reset)
        (i_upd_valid && !i_upd_open) |-> open_q[i_upd_bank])
        else $error("PRE to a bank that is already closed");

endmodule

/* mc_cmd_scheduler.sv */
/*
 * Command scheduler
 * turns the head request into PRE / ACT / CAS depending on
 * the bank's page state; holds tRP and tRCD between commands
 * and pops the request together with its CAS
 */

`timescale 1ns/1ps

module mc_cmd_scheduler #(
    parameter int T_RP  = 4,
    parameter int T_RCD = 3
) (
    input  logic              clk,
    input  logic              i_reset,
    // head of the request queue
    input  logic              i_valid,
    input  logic              i_write,
    input  mc_pkg::bank_t     i_bank,
    input  mc_pkg::row_t      i_row,
    input  mc_pkg::col_t      i_col,
    output logic              o_pop,
    // page table
    output mc_pkg::bank_t     o_lookup_bank,
    input  logic              i_open,
    input  mc_pkg::row_t      i_open_row,
    output logic              o_upd_valid,
    output logic              o_upd_open,
    output mc_pkg::bank_t     o_upd_bank,
    output mc_pkg::row_t      o_upd_row,
    // command output
    output logic              o_cmd_valid,
    output mc_pkg::dram_cmd_e o_cmd,
    output mc_pkg::bank_t     o_cmd_bank,
    output mc_pkg::row_t      o_cmd_row,
    output mc_pkg::col_t      o_cmd_col
);

    localparam int T_MAX   = (T_RP > T_RCD) ? T_RP : T_RCD;
    localparam int TIMER_W = (T_MAX > 1) ? $clog2(T_MAX) : 1;

    typedef enum logic [1:0] {
        ST_IDLE,      // waiting for a head request
        ST_WAIT_PRE,  // PRE issued, counting tRP
        ST_WAIT_ACT,  // ACT issued, counting tRCD
        ST_GAP        // CAS on the bus, pop in flight
    } state_e;

    state_e              state_q;
    state_e              state_d;
    logic [TIMER_W-1:0]  timer_q;
    logic [TIMER_W-1:0]  timer_d;

    logic                issue;
    mc_pkg::dram_cmd_e   issue_cmd;
    logic                row_hit;
    logic                pop_q;

    mc_pkg::dram_cmd_e   cmd_q;
    logic                cmd_valid_q;
    mc_pkg::bank_t       cmd_bank_q;
    mc_pkg::row_t        cmd_row_q;
    mc_pkg::col_t        cmd_col_q;

    // the head is the only request looked at
    assign o_lookup_bank = i_bank;
    assign row_hit       = i_open && (i_open_row == i_row);

    ////////////////////////////////////////////////////////////////////////////
    // next state
    ////////////////////////////////////////////////////////////////////////////

    always_comb begin
        state_d     = state_q;
        timer_d     = timer_q;
        issue       = 1'b0;
        issue_cmd   = mc_pkg::CMD_NOP;
        o_upd_valid = 1'b0;
        o_upd_open  = 1'b0;

        case (state_q)
            ST_IDLE: begin
                if (i_valid) begin
                    issue = 1'b1;
                    if (row_hit) begin
                        issue_cmd = i_write ? mc_pkg::CMD_WR : mc_pkg::CMD_RD;
                        state_d   = ST_GAP;
                    end else if (!i_open) begin
                        issue_cmd   = mc_pkg::CMD_ACT;
                        o_upd_valid = 1'b1;
                        o_upd_open  = 1'b1;
                        timer_d     = TIMER_W'(T_RCD - 1);
                        state_d     = ST_WAIT_ACT;
                    end else begin
                        issue_cmd   = mc_pkg::CMD_PRE;  // other row open
                        o_upd_valid = 1'b1;
                        timer_d     = TIMER_W'(T_RP - 1);
                        state_d     = ST_WAIT_PRE;
                    end
                end
            end

            ST_WAIT_PRE: begin
                if (timer_q == '0) begin
                    issue       = 1'b1;
                    issue_cmd   = mc_pkg::CMD_ACT;
                    o_upd_valid = 1'b1;
                    o_upd_open  = 1'b1;
                    timer_d     = TIMER_W'(T_RCD - 1);
                    state_d     = ST_WAIT_ACT;
                end else begin
                    timer_d = timer_q - 1'b1;
                end
            end

            ST_WAIT_ACT: begin
                if (timer_q == '0) begin
                    issue     = 1'b1;
                    issue_cmd = i_write ? mc_pkg::CMD_WR : mc_pkg::CMD_RD;
                    state_d   = ST_GAP;
                end else begin
                    timer_d = timer_q - 1'b1;
                end
            end

            default: begin
                state_d = ST_IDLE;  // queue advances this cycle
            end
        endcase
    end

    assign o_upd_bank = i_bank;
    assign o_upd_row  = i_row;

    ////////////////////////////////////////////////////////////////////////////
    // registers
    ////////////////////////////////////////////////////////////////////////////

    always_ff @(posedge clk) begin
        if (i_reset) begin
            state_q     <= ST_IDLE;
            timer_q     <= '0;
            cmd_valid_q <= 1'b0;
            cmd_q       <= mc_pkg::CMD_NOP;
            pop_q       <= 1'b0;
        end else begin
            state_q     <= state_d;
            timer_q     <= timer_d;
            cmd_valid_q <= issue;
            cmd_q       <= issue_cmd;
            // pop goes out in the same cycle as the CAS
            pop_q       <= issue && (state_d == ST_GAP);
        end
    end

    // address fields, don't care for a NOP
    always_ff @(posedge clk) begin
        cmd_bank_q <= i_bank;
        cmd_row_q  <= i_row;
        cmd_col_q  <= i_col;
    end

    assign o_pop       = pop_q;
    assign o_cmd_valid = cmd_valid_q;
    assign o_cmd       = cmd_q;
    assign o_cmd_bank  = cmd_bank_q;
    assign o_cmd_row   = cmd_row_q;
    assign o_cmd_col   = cmd_col_q;

    a_valid_not_nop: assert property (@(posedge clk) disable iff (i_reset)
        o_cmd_valid |-> (o_cmd != mc_pkg::CMD_NOP))
        else $error("command valid with CMD_NOP");

endmodule

/* mc_cmd_top.sv */
/*
 * DRAM command path, top level
 * request queue -> scheduler with page table -> command bus
 */

`timescale 1ns/1ps

module mc_cmd_top #(
    parameter int QUEUE_DEPTH = 4,
    parameter int T_RP        = 4,
    parameter int T_RCD       = 3
) (
    input  logic              clk,
    input  logic              i_reset,
    // request port, four-phase
    input  logic              i_req,
    input  logic              i_req_write,
    input  mc_pkg::bank_t     i_req_bank,
    input  mc_pkg::row_t      i_req_row,
    input  mc_pkg::col_t      i_req_col,
    output logic              o_ack,
    // command bus
    output logic              o_cmd_valid,
    output mc_pkg::dram_cmd_e o_cmd,
    output mc_pkg::bank_t     o_cmd_bank,
    output mc_pkg::row_t      o_cmd_row,
    output mc_pkg::col_t      o_cmd_col
);

    // queue head
    logic          q_valid;
    logic          q_write;
    mc_pkg::bank_t q_bank;
    mc_pkg::row_t  q_row;
    mc_pkg::col_t  q_col;
    logic          q_pop;

    // page table
    mc_pkg::bank_t lookup_bank;
    logic          page_open;
    mc_pkg::row_t  page_row;
    logic          upd_valid;
    logic          upd_open;
    mc_pkg::bank_t upd_bank;
    mc_pkg::row_t  upd_row;

    mc_request_queue #(
        .QUEUE_DEPTH (QUEUE_DEPTH)
    ) u_queue (
        .clk         (clk),
        .i_reset     (i_reset),
        .i_req       (i_req),
        .i_req_write (i_req_write),
        .i_req_bank  (i_req_bank),
        .i_req_row   (i_req_row),
        .i_req_col   (i_req_col),
        .o_ack       (o_ack),
        .i_pop       (q_pop),
        .o_valid     (q_valid),
        .o_write     (q_write),
        .o_bank      (q_bank),
        .o_row       (q_row),
        .o_col       (q_col)
    );

    mc_cmd_scheduler #(
        .T_RP  (T_RP),
        .T_RCD (T_RCD)
    ) u_sched (
        .clk           (clk),
        .i_reset       (i_reset),
        .i_valid       (q_valid),
        .i_write       (q_write),
        .i_bank        (q_bank),
        .i_row         (q_row),
        .i_col         (q_col),
        .o_pop         (q_pop),
        .o_lookup_bank (lookup_bank),
        .i_open        (page_open),
        .i_open_row    (page_row),
        .o_upd_valid   (upd_valid),
        .o_upd_open    (upd_open),
        .o_upd_bank    (upd_bank),
        .o_upd_row     (upd_row),
        .o_cmd_valid   (o_cmd_valid),
        .o_cmd         (o_cmd),
        .o_cmd_bank    (o_cmd_bank),
        .o_cmd_row     (o_cmd_row),
        .o_cmd_col     (o_cmd_col)
    );

    mc_page_table u_pages (
        .clk           (clk),
        .i_reset       (i_reset),
        .i_lookup_bank (lookup_bank),
        .o_open        (page_open),
        .o_open_row    (page_row),
        .i_upd_valid   (upd_valid),
        .i_upd_open    (upd_open),
        .i_upd_bank    (upd_bank),
        .i_upd_row     (upd_row)
    );

endmodule

/* tb_mc_cmd.sv */
/*
 * Testbench for the DRAM command path
 * random four-phase requests from an xorshift source, a model of
 * per-bank page state that predicts every PRE / ACT / CAS, and
 * checks on command order, spacing and the req/ack handshake
 */

`timescale 1ns/1ps

module tb_mc_cmd;

    localparam int QUEUE_DEPTH    = 4;
    localparam int T_RP           = 4;
    localparam int T_RCD          = 3;
    localparam int NUM_REQ        = 200;
    localparam int TIMEOUT_CYCLES = NUM_REQ * (T_RP + T_RCD + 12) + 100;
    localparam int DRAIN_CYCLES   = (QUEUE_DEPTH + 1) * (T_RP + T_RCD + 2) + 20;

    logic              clk;
    logic              i_reset;
    logic              i_req;
    logic              i_req_write;
    mc_pkg::bank_t     i_req_bank;
    mc_pkg::row_t      i_req_row;
    mc_pkg::col_t      i_req_col;
    logic              o_ack;
    logic              o_cmd_valid;
    mc_pkg::dram_cmd_e o_cmd;
    mc_pkg::bank_t     o_cmd_bank;
    mc_pkg::row_t      o_cmd_row;
    mc_pkg::col_t      o_cmd_col;

    logic [31:0] rng_state = 32'ha5a9123e;
    int          cycles = 0;
    int          mismatches = 0;
    int          other_errors = 0;
    int          handshakes = 0;
    int          cas_count = 0;
    int          last_cmd_cycle = 0;
    logic        cmd_seen = 1'b0;
    logic        ack_prev = 1'b0;
    logic        req_at_edge = 1'b0;  // i_req as the DUT saw it

    // model of the page table
    logic         bank_open [mc_pkg::NUM_BANKS];
    mc_pkg::row_t bank_row  [mc_pkg::NUM_BANKS];

    // expected commands, oldest first
    mc_pkg::dram_cmd_e exp_cmd  [$];
    mc_pkg::bank_t     exp_bank [$];
    mc_pkg::row_t      exp_row  [$];
    mc_pkg::col_t      exp_col  [$];
    int                exp_gap  [$];  // exact spacing, 0 when free

    mc_cmd_top #(
        .QUEUE_DEPTH (QUEUE_DEPTH),
        .T_RP        (T_RP),
        .T_RCD       (T_RCD)
    ) dut0 (
        .clk         (clk),
        .i_reset     (i_reset),
        .i_req       (i_req),
        .i_req_write (i_req_write),
        .i_req_bank  (i_req_bank),
        .i_req_row   (i_req_row),
        .i_req_col   (i_req_col),
        .o_ack       (o_ack),
        .o_cmd_valid (o_cmd_valid),
        .o_cmd       (o_cmd),
        .o_cmd_bank  (o_cmd_bank),
        .o_cmd_row   (o_cmd_row),
        .o_cmd_col   (o_cmd_col)
    );

    initial begin
        clk = 1'b0;
        forever #2 clk = ~clk;
    end

    ////////////////////////////////////////////////////////////////////////////
    // random source and compare tasks
    ////////////////////////////////////////////////////////////////////////////

    function automatic logic [31:0] xorshift32(input logic [31:0] s);
        logic [31:0] x;
        x = s;
        x = x ^ (x << 13);
        x = x ^ (x >> 17);
        x = x ^ (x << 5);
        return x;
    endfunction

    function automatic logic [31:0] next_rand();
        rng_state = xorshift32(rng_state);
        return rng_state;
    endfunction

    // few rows, so hits and misses both show up
    function automatic mc_pkg::row_t pick_row(input logic [1:0] k);
        case (k)
            2'd0:    return 16'h0010;
            2'd1:    return 16'h0020;
            2'd2:    return 16'h1234;
            default: return 16'hbeef;
        endcase
    endfunction

    task automatic check_cmd(input string name, input mc_pkg::dram_cmd_e got,
                             input mc_pkg::dram_cmd_e exp);
        if (got !== exp) begin
            mismatches++;
            $display("Mismatch at %0t: %s got %s expected %s", $time, name,
                     got.name(), exp.name());
        end
    endtask

    task automatic check_bank(input string name, input mc_pkg::bank_t got,
                              input mc_pkg::bank_t exp);
        if (got !== exp) begin
            mismatches++;
            $display("Mismatch at %0t: %s got %0d expected %0d", $time, name, got, exp);
        end
    endtask

    task automatic check_row(input string name, input mc_pkg::row_t got,
                             input mc_pkg::row_t exp);
        if (got !== exp) begin
            mismatches++;
            $display("Mismatch at %0t: %s got 0x%h expected 0x%h", $time, name, got, exp);
        end
    endtask

    task automatic check_col(input string name, input mc_pkg::col_t got,
                             input mc_pkg::col_t exp);
        if (got !== exp) begin
            mismatches++;
            $display("Mismatch at %0t: %s got 0x%h expected 0x%h", $time, name, got, exp);
        end
    endtask

    task automatic check_flag(input string name, input logic got, input logic exp);
        if (got !== exp) begin
            mismatches++;
            $display("Mismatch at %0t: %s got %b expected %b", $time, name, got, exp);
        end
    endtask

    task automatic check_int(input string name, input int got, input int exp);
        if (got != exp) begin
            mismatches++;
            $display("Mismatch at %0t: %s got %0d expected %0d", $time, name, got, exp);
        end
    endtask

    ////////////////////////////////////////////////////////////////////////////
    // reference model
    ////////////////////////////////////////////////////////////////////////////

    task automatic push_expected(input mc_pkg::dram_cmd_e cmd, input mc_pkg::bank_t bank,
                                 input mc_pkg::row_t row, input mc_pkg::col_t col,
                                 input int gap);
        exp_cmd.push_back(cmd);
        exp_bank.push_back(bank);
        exp_row.push_back(row);
        exp_col.push_back(col);
        exp_gap.push_back(gap);
    endtask

    // requests are served in order, so the page state at acceptance is final
    task automatic model_accept(input logic write, input mc_pkg::bank_t bank,
                                input mc_pkg::row_t row, input mc_pkg::col_t col);
        mc_pkg::dram_cmd_e cas;
        cas = write ? mc_pkg::CMD_WR : mc_pkg::CMD_RD;
        if (bank_open[bank] && bank_row[bank] == row) begin
            push_expected(cas, bank, row, col, 0);  // row hit
        end else begin
            if (bank_open[bank])
                push_expected(mc_pkg::CMD_PRE, bank, row, col, 0);
            push_expected(mc_pkg::CMD_ACT, bank, row, col, bank_open[bank] ? T_RP : 0);
            push_expected(cas, bank, row, col, T_RCD);
            bank_open[bank] = 1'b1;
            bank_row[bank]  = row;
        end
    endtask

    task automatic check_command();
        mc_pkg::dram_cmd_e e_cmd;
        int                e_gap;
        if (exp_cmd.size() == 0) begin
            other_errors++;
            $display("unexpected %s on bank %0d at %0t with nothing outstanding",
                     o_cmd.name(), o_cmd_bank, $time);
        end else begin
            e_cmd = exp_cmd.pop_front();
            e_gap = exp_gap.pop_front();
            check_cmd("o_cmd", o_cmd, e_cmd);
            check_bank("o_cmd_bank", o_cmd_bank, exp_bank.pop_front());
            if (e_cmd == mc_pkg::CMD_ACT)
                check_row("o_cmd_row", o_cmd_row, exp_row.pop_front());
            else
                void'(exp_row.pop_front());
            if (e_cmd == mc_pkg::CMD_RD || e_cmd == mc_pkg::CMD_WR)
                check_col("o_cmd_col", o_cmd_col, exp_col.pop_front());
            else
                void'(exp_col.pop_front());
            if (e_gap != 0) begin
                check_int("command spacing", cycles - last_cmd_cycle, e_gap);
            end else if (cmd_seen && cycles - last_cmd_cycle < 2) begin
                other_errors++;
                $display("no idle cycle before %s at %0t", o_cmd.name(), $time);
            end
        end
        if (o_cmd == mc_pkg::CMD_RD || o_cmd == mc_pkg::CMD_WR)
            cas_count++;
        last_cmd_cycle = cycles;
        cmd_seen       = 1'b1;
    endtask

    ////////////////////////////////////////////////////////////////////////////
    // monitor and watchdog
    ////////////////////////////////////////////////////////////////////////////

    always @(posedge clk) begin
        req_at_edge <= i_req;
        cycles      <= cycles + 1;
        if (cycles == TIMEOUT_CYCLES) begin
            $display("timeout after %0d cycles, %0d of %0d handshakes done",
                     cycles, handshakes, NUM_REQ);
            $display("Done: errors found");
            $finish;
        end
    end

    always @(negedge clk) begin
        if (!i_reset) begin
            if (o_cmd_valid)
                check_command();
            if (o_ack && !ack_prev) begin
                if (!req_at_edge) begin
                    other_errors++;
                    $display("o_ack rose while i_req was low at %0t", $time);
                end
                handshakes++;
                model_accept(i_req_write, i_req_bank, i_req_row, i_req_col);
            end
            if (!o_ack && ack_prev && req_at_edge) begin
                other_errors++;
                $display("o_ack fell while i_req was high at %0t", $time);
            end
            ack_prev = o_ack;
        end
    end

    ////////////////////////////////////////////////////////////////////////////
    // stimulus
    ////////////////////////////////////////////////////////////////////////////

    initial begin
        logic [31:0] r;
        int          drain;
        i_reset     = 1'b1;
        i_req       = 1'b0;
        i_req_write = 1'b0;
        i_req_bank  = '0;
        i_req_row   = '0;
        i_req_col   = '0;
        for (int b = 0; b < mc_pkg::NUM_BANKS; b++) begin
            bank_open[b] = 1'b0;  // all banks precharged
            bank_row[b]  = '0;
        end
        repeat (2) @(negedge clk);
        i_reset = 1'b0;
        check_flag("o_ack", o_ack, 1'b0);
        check_flag("o_cmd_valid", o_cmd_valid, 1'b0);

        for (int n = 0; n < NUM_REQ; n++) begin
            r = next_rand();
            if (r[31:30] == 2'b00)
                repeat (r[29:27]) @(negedge clk);  // mostly back to back
            r = next_rand();
            i_req_write = r[0];
            i_req_bank  = r[3:1];
            i_req_row   = pick_row(r[5:4]);
            i_req_col   = r[15:6];
            i_req       = 1'b1;
            @(negedge clk);
            while (o_ack !== 1'b1)
                @(negedge clk);
            if (r[31:30] == 2'b00)
                repeat (r[29:28]) @(negedge clk);
            i_req = 1'b0;
            @(negedge clk);
            while (o_ack !== 1'b0)
                @(negedge clk);
        end

        // let the scheduler drain, then watch for strays
        drain = 0;
        while (exp_cmd.size() != 0 && drain < DRAIN_CYCLES) begin
            @(posedge clk);
            drain++;
        end
        repeat (20) @(posedge clk);

        check_int("handshakes", handshakes, NUM_REQ);
        check_int("CAS commands", cas_count, handshakes);
        if (exp_cmd.size() != 0) begin
            other_errors++;
            $display("%0d expected commands never issued", exp_cmd.size());
        end
        $display("mismatches %0d, other errors %0d, handshakes %0d, CAS commands %0d",
                 mismatches, other_errors, handshakes, cas_count);
        if (mismatches == 0 && other_errors == 0)
            $display("Done: no errors");
        else
            $display("Done: errors found");
        $finish;
    end

endmodule

/* vlog.f */
mc_pkg.sv
mc_request_queue.sv
mc_page_table.sv
mc_cmd_scheduler.sv
mc_cmd_top.sv
tb_mc_cmd.sv

/* run_sim.sh */
#!/bin/sh
# build the DRAM command path testbench with Verilator and run it
rm -rf obj_dir sim.log
verilator --binary --timing --assert -f vlog.f --top-module tb_mc_cmd -o tb_mc_cmd \
    && ./obj_dir/tb_mc_cmd > sim.log 2>&1 \
    || { cat sim.log 2>/dev/null; echo "build or simulation failed"; exit 1; }
cat sim.log
grep -q "Done: no errors" sim.log \
    && echo "PASS" \
    || { echo "FAIL"; exit 1; }
